//--- vlog.f
hw/ao_periph_pkg.sv
hw/ao_periph_xbar.sv
hw/soc_ctrl.sv
hw/ao_timer.sv
hw/gpio_ao.sv
hw/fast_intr_ctrl.sv
hw/ao_peripheral_subsystem.sv
bench/ao_checker.sv
bench/tb_ao_peripheral_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       ?= tb_ao_peripheral_subsystem
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Output goes to the console and is searched for the pass message
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_ao_peripheral_subsystem.sv
/* Testbench top: clock, reset, random bus traffic and pin stimulus
   on falling edges, DUT and checker instances */
`timescale 1ns/10ps

module tb_ao_peripheral_subsystem
  import ao_periph_pkg::*;
();

  localparam int unsigned NUM_GPIO      = 8;
  localparam int unsigned NUM_FAST_INTR = 15;
  localparam logic [31:0] SOC_BASE      = 32'h2000_0000;
  localparam logic [31:0] TIMER_BASE    = 32'h2000_1000;
  localparam logic [31:0] GPIO_BASE     = 32'h2000_2000;
  localparam logic [31:0] FAST_BASE     = 32'h2000_3000;

  localparam logic [31:0] DEFINED_REGS [15] = '{
    32'h2000_0000, 32'h2000_0004, 32'h2000_0008, 32'h2000_000C,
    32'h2000_1000, 32'h2000_1004, 32'h2000_1008, 32'h2000_100C,
    32'h2000_2000, 32'h2000_2004, 32'h2000_2008, 32'h2000_200C,
    32'h2000_2010, 32'h2000_3000, 32'h2000_3004
  };

  // SCRATCH, EXIT_VALUE, DATA_OUT, OUT_EN, INTR_EN, ENABLE
  localparam logic [31:0] RW_REGS [6] = '{
    32'h2000_000C, 32'h2000_0004, 32'h2000_2004,
    32'h2000_2008, 32'h2000_200C, 32'h2000_3004
  };

  logic                     clk;
  logic                     rst_n;
  obi_req_t                 slave_req;
  obi_resp_t                slave_resp;
  logic                     boot_select;
  logic [NUM_GPIO-1:0]      gpio_in;
  logic [NUM_GPIO-1:0]      gpio_out;
  logic [NUM_GPIO-1:0]      gpio_en;
  logic [NUM_GPIO-1:0]      intr_gpio;
  logic                     exit_valid;
  logic [31:0]              exit_value;
  logic                     timer_intr;
  logic [NUM_FAST_INTR-1:0] fast_intr_in;
  logic [NUM_FAST_INTR-1:0] fast_intr_out;
  int unsigned              mismatches;
  int unsigned              timeouts;
  int unsigned              tries;
  int unsigned              pick;
  logic [31:0]              rdata;
  logic [31:0]              addr;

  always #20 clk = ~clk;

  ao_peripheral_subsystem #(
    .NUM_GPIO      (NUM_GPIO),
    .NUM_FAST_INTR (NUM_FAST_INTR)
  ) ao_peripheral_subsystem_inst (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .slave_req_i   (slave_req),
    .slave_resp_o  (slave_resp),
    .boot_select_i (boot_select),
    .exit_valid_o  (exit_valid),
    .exit_value_o  (exit_value),
    .gpio_i        (gpio_in),
    .gpio_o        (gpio_out),
    .gpio_en_o     (gpio_en),
    .intr_gpio_o   (intr_gpio),
    .timer_intr_o  (timer_intr),
    .fast_intr_i   (fast_intr_in),
    .fast_intr_o   (fast_intr_out)
  );

  ao_checker #(
    .NUM_GPIO      (NUM_GPIO),
    .NUM_FAST_INTR (NUM_FAST_INTR)
  ) ao_checker_inst (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .slave_req_i      (slave_req),
    .slave_resp_i     (slave_resp),
    .boot_select_i    (boot_select),
    .gpio_in_i        (gpio_in),
    .fast_intr_in_i   (fast_intr_in),
    .exit_valid_i     (exit_valid),
    .exit_value_i     (exit_value),
    .gpio_out_i       (gpio_out),
    .gpio_en_i        (gpio_en),
    .intr_gpio_i      (intr_gpio),
    .timer_intr_i     (timer_intr),
    .fast_intr_out_i  (fast_intr_out),
    .mismatch_count_o (mismatches)
  );

  task automatic issue_access(input logic we, input logic [31:0] a, input logic [31:0] wdata,
                              input logic [3:0] be);
    @(negedge clk);
    slave_req.req   = 1'b1;
    slave_req.we    = we;
    slave_req.addr  = a;
    slave_req.wdata = wdata;
    slave_req.be    = be;
  endtask

  task automatic release_bus();
    @(negedge clk);
    slave_req = '0;
  endtask

  // One access on its own, then wait for its response
  task automatic single_access(input logic we, input logic [31:0] a, input logic [31:0] wdata,
                               output logic [31:0] data);
    int unsigned n;
    issue_access(we, a, wdata, 4'hF);
    release_bus();
    n = 0;
    while (!slave_resp.rvalid && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (!slave_resp.rvalid) begin
      $display("timeout: no bus response for address %h", a);
      timeouts++;
    end
    data = slave_resp.rdata;
  endtask

  task automatic write_word(input logic [31:0] a, input logic [31:0] wdata);
    logic [31:0] unused;
    single_access(1'b1, a, wdata, unused);
  endtask

  task automatic read_word(input logic [31:0] a, output logic [31:0] data);
    single_access(1'b0, a, 32'h0, data);
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    slave_req    = '0;
    gpio_in      = '0;
    fast_intr_in = '0;
    timeouts     = 0;
    void'($urandom(32'h2bbd));
    boot_select  = 1'($urandom);
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    // Reset values
    for (int i = 0; i < 15; i++) begin
      read_word(DEFINED_REGS[i], rdata);
    end

    // Readback of the other boot-select level
    @(negedge clk);
    boot_select = ~boot_select;
    read_word(SOC_BASE + 32'h8, rdata);

    // Back-to-back traffic on the read/write registers
    for (int i = 0; i < 200; i++) begin
      pick = $urandom % 6;
      issue_access(1'($urandom), RW_REGS[pick], $urandom, 4'($urandom));
    end
    release_bus();

    // Unmapped bases, slot indices of 4 and up, unknown offsets
    for (int i = 0; i < 60; i++) begin
      addr = $urandom;
      case (i % 3)
        0: begin
          if (addr[31:16] == 16'h2000) begin
            addr[31:16] = 16'h4000;
          end
        end
        1: addr = {16'h2000, 4'(4 + $urandom % 12), addr[11:0]};
        default: addr = {16'h2000, 4'($urandom % 4), 4'h1, addr[7:2], 2'b00};
      endcase
      issue_access(1'($urandom), addr, $urandom, 4'hF);
    end
    release_bus();

    // Exit status
    write_word(SOC_BASE + 32'h4, $urandom);
    write_word(SOC_BASE, 32'h1);
    tries = 0;
    while (!exit_valid && tries < 20) begin
      @(negedge clk);
      tries++;
    end
    if (!exit_valid) begin
      $display("timeout: exit_valid_o did not rise");
      timeouts++;
    end
    write_word(SOC_BASE, 32'h0);

    // GPIO with pin 1 enabled and pin 7 disabled first
    write_word(GPIO_BASE + 32'hC, 32'h0000_000F);
    for (int round = 0; round < 6; round++) begin
      @(negedge clk);
      gpio_in = (round == 0) ? NUM_GPIO'(8'h82) : NUM_GPIO'($urandom);
      tries = 0;
      rdata = ~32'(gpio_in);
      while (rdata[NUM_GPIO-1:0] != gpio_in && tries < 20) begin
        read_word(GPIO_BASE, rdata);
        tries++;
      end
      if (rdata[NUM_GPIO-1:0] != gpio_in) begin
        $display("timeout: DATA_IN did not follow the pins");
        timeouts++;
      end
      if (round == 0 && !intr_gpio[1]) begin
        $display("timeout: rising edge on pin 1 raised no interrupt");
        timeouts++;
      end
      read_word(GPIO_BASE + 32'h10, rdata);
      write_word(GPIO_BASE + 32'h10, 32'hFFFF_FFFF);
      read_word(GPIO_BASE + 32'h10, rdata);
    end

    // Fast interrupts, line 1 pending but masked by ENABLE
    write_word(FAST_BASE + 32'h4, 32'h0000_0055);
    @(negedge clk);
    fast_intr_in = NUM_FAST_INTR'(15'h0007);
    @(negedge clk);
    fast_intr_in = '0;
    tries = 0;
    while (!fast_intr_out[0] && tries < 20) begin
      @(negedge clk);
      tries++;
    end
    if (!fast_intr_out[0]) begin
      $display("timeout: fast_intr_o bit 0 did not rise");
      timeouts++;
    end
    read_word(FAST_BASE, rdata);
    write_word(FAST_BASE, 32'h0000_0007);
    read_word(FAST_BASE, rdata);

    // Timer
    write_word(TIMER_BASE + 32'h8, 32'd20 + $urandom % 20);
    write_word(TIMER_BASE, 32'h3);
    tries = 0;
    while (!timer_intr && tries < 200) begin
      @(negedge clk);
      tries++;
    end
    if (!timer_intr) begin
      $display("timeout: timer_intr_o did not rise");
      timeouts++;
    end
    for (int i = 0; i < 5; i++) begin
      read_word(TIMER_BASE + 32'h4, rdata);
    end
    write_word(TIMER_BASE, 32'h0);
    write_word(TIMER_BASE + 32'hC, 32'h1);
    read_word(TIMER_BASE + 32'hC, rdata);

    repeat (3) @(negedge clk);
    $display("mismatches: %0d, timeouts: %0d", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- bench/ao_checker.sv
/* Bus monitor with a cycle model of the peripheral registers,
   response and output comparisons, mismatch counter */
`timescale 1ns/10ps

module ao_checker
  import ao_periph_pkg::*;
#(
  parameter int unsigned NUM_GPIO      = 8,
  parameter int unsigned NUM_FAST_INTR = 15
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  obi_req_t                 slave_req_i,
  input  obi_resp_t                slave_resp_i,
  input  logic                     boot_select_i,
  input  logic [NUM_GPIO-1:0]      gpio_in_i,
  input  logic [NUM_FAST_INTR-1:0] fast_intr_in_i,
  input  logic                     exit_valid_i,
  input  logic [31:0]              exit_value_i,
  input  logic [NUM_GPIO-1:0]      gpio_out_i,
  input  logic [NUM_GPIO-1:0]      gpio_en_i,
  input  logic [NUM_GPIO-1:0]      intr_gpio_i,
  input  logic                     timer_intr_i,
  input  logic [NUM_FAST_INTR-1:0] fast_intr_out_i,
  output int unsigned              mismatch_count_o
);

  typedef struct packed {
    logic        valid;
    logic        gnt_bad;
    logic        err;
    logic [31:0] rdata;
    logic [31:0] addr;
  } expect_t;

  expect_t                  exp;
  int unsigned              errors = 0;
  logic [32:0]              rd;
  logic                     hit;
  logic                     wr;
  logic [15:0]              wsel;
  logic [31:0]              wdata;
  logic [31:0]              merged;
  logic [NUM_GPIO-1:0]      gpio_clr;
  logic [NUM_FAST_INTR-1:0] fast_clr;

  // Register model
  logic                     m_exit_valid;
  logic [31:0]              m_exit_value;
  logic [31:0]              m_scratch;
  logic                     m_cnt_en;
  logic                     m_intr_en;
  logic [31:0]              m_mtime;
  logic [31:0]              m_mtimecmp;
  logic                     m_status;
  logic [NUM_GPIO-1:0]      m_sync1;
  logic [NUM_GPIO-1:0]      m_sync2;
  logic [NUM_GPIO-1:0]      m_prev;
  logic [NUM_GPIO-1:0]      m_data_out;
  logic [NUM_GPIO-1:0]      m_out_en;
  logic [NUM_GPIO-1:0]      m_gpio_ie;
  logic [NUM_GPIO-1:0]      m_gpio_is;
  logic [NUM_FAST_INTR-1:0] m_pending;
  logic [NUM_FAST_INTR-1:0] m_enable;

  assign mismatch_count_o = errors;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (new_val & mask) | (old_val & ~mask);
  endfunction

  // Bit 32 flags an unknown register
  function automatic logic [32:0] lookup_register(input logic [3:0] idx, input logic [11:0] ofs);
    logic [32:0] r;
    r = '0;
    case ({idx, ofs})
      16'h0000: r[31:0] = {31'b0, m_exit_valid};
      16'h0004: r[31:0] = m_exit_value;
      16'h0008: r[31:0] = {31'b0, boot_select_i};
      16'h000C: r[31:0] = m_scratch;
      16'h1000: r[31:0] = {30'b0, m_intr_en, m_cnt_en};
      16'h1004: r[31:0] = m_mtime;
      16'h1008: r[31:0] = m_mtimecmp;
      16'h100C: r[31:0] = {31'b0, m_status};
      16'h2000: r[31:0] = 32'(m_sync2);
      16'h2004: r[31:0] = 32'(m_data_out);
      16'h2008: r[31:0] = 32'(m_out_en);
      16'h200C: r[31:0] = 32'(m_gpio_ie);
      16'h2010: r[31:0] = 32'(m_gpio_is);
      16'h3000: r[31:0] = 32'(m_pending);
      16'h3004: r[31:0] = 32'(m_enable);
      default:  r[32] = 1'b1;
    endcase
    return r;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
    errors++;
  endtask

  // Sample the request and step the model at the accepting edge
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exp          = '0;
      m_exit_valid = 1'b0;
      m_exit_value = '0;
      m_scratch    = '0;
      m_cnt_en     = 1'b0;
      m_intr_en    = 1'b0;
      m_mtime      = '0;
      m_mtimecmp   = '0;
      m_status     = 1'b0;
      m_sync1      = '0;
      m_sync2      = '0;
      m_prev       = '0;
      m_data_out   = '0;
      m_out_en     = '0;
      m_gpio_ie    = '0;
      m_gpio_is    = '0;
      m_pending    = '0;
      m_enable     = '0;
    end else begin
      rd          = lookup_register(slave_req_i.addr[15:12], slave_req_i.addr[11:0]);
      hit         = (slave_req_i.addr[31:16] == 16'h2000) && !rd[32];
      exp.valid   = slave_req_i.req;
      exp.gnt_bad = slave_resp_i.gnt !== slave_req_i.req;
      exp.err     = slave_req_i.req && !hit;
      exp.rdata   = (slave_req_i.req && hit && !slave_req_i.we) ? rd[31:0] : 32'h0;
      exp.addr    = slave_req_i.addr;
      wr          = slave_req_i.req && slave_req_i.we && hit;
      wsel        = slave_req_i.addr[15:0];
      wdata       = slave_req_i.wdata;
      gpio_clr    = (wr && wsel == 16'h2010) ? wdata[NUM_GPIO-1:0] : '0;
      fast_clr    = (wr && wsel == 16'h3000) ? wdata[NUM_FAST_INTR-1:0] : '0;

      // Status set has priority over the clear
      if (m_cnt_en && m_mtime >= m_mtimecmp) begin
        m_status = 1'b1;
      end else if (wr && wsel == 16'h100C && wdata[0]) begin
        m_status = 1'b0;
      end
      if (m_cnt_en) begin
        m_mtime = m_mtime + 32'd1;
      end
      m_gpio_is = (m_gpio_is & ~gpio_clr) | (m_sync2 & ~m_prev & m_gpio_ie);
      m_prev    = m_sync2;
      m_sync2   = m_sync1;
      m_sync1   = gpio_in_i;
      m_pending = (m_pending & ~fast_clr) | fast_intr_in_i;

      if (wr) begin
        case (wsel)
          16'h0000: begin
            if (wdata[0]) begin
              m_exit_valid = 1'b1;
            end
          end
          16'h0004: m_exit_value = wdata;
          16'h000C: m_scratch = merge_bytes(m_scratch, wdata, slave_req_i.be);
          16'h1000: {m_intr_en, m_cnt_en} = wdata[1:0];
          16'h1008: m_mtimecmp = wdata;
          16'h2004: begin
            merged     = merge_bytes(32'(m_data_out), wdata, slave_req_i.be);
            m_data_out = merged[NUM_GPIO-1:0];
          end
          16'h2008: m_out_en = wdata[NUM_GPIO-1:0];
          16'h200C: m_gpio_ie = wdata[NUM_GPIO-1:0];
          16'h3004: m_enable = wdata[NUM_FAST_INTR-1:0];
          default: ;
        endcase
      end
    end
  end

  // Registered outputs are stable here
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (exp.gnt_bad) begin
        report_mismatch("gnt", 32'(!exp.valid), 32'(exp.valid));
      end
      if (slave_resp_i.rvalid !== exp.valid) begin
        report_mismatch("rvalid", 32'(slave_resp_i.rvalid), 32'(exp.valid));
      end
      if (exp.valid && slave_resp_i.err !== exp.err) begin
        report_mismatch($sformatf("err from %h", exp.addr), 32'(slave_resp_i.err),
                        32'(exp.err));
      end
      if (exp.valid && slave_resp_i.rdata !== exp.rdata) begin
        report_mismatch($sformatf("rdata from %h", exp.addr), slave_resp_i.rdata, exp.rdata);
      end
      if (exit_valid_i !== m_exit_valid) begin
        report_mismatch("exit_valid_o", 32'(exit_valid_i), 32'(m_exit_valid));
      end
      if (exit_value_i !== m_exit_value) begin
        report_mismatch("exit_value_o", exit_value_i, m_exit_value);
      end
      if (gpio_out_i !== m_data_out) begin
        report_mismatch("gpio_o", 32'(gpio_out_i), 32'(m_data_out));
      end
      if (gpio_en_i !== m_out_en) begin
        report_mismatch("gpio_en_o", 32'(gpio_en_i), 32'(m_out_en));
      end
      if (intr_gpio_i !== m_gpio_is) begin
        report_mismatch("intr_gpio_o", 32'(intr_gpio_i), 32'(m_gpio_is));
      end
      if (timer_intr_i !== (m_status && m_intr_en)) begin
        report_mismatch("timer_intr_o", 32'(timer_intr_i), 32'(m_status && m_intr_en));
      end
      if (fast_intr_out_i !== (m_pending & m_enable)) begin
        report_mismatch("fast_intr_o", 32'(fast_intr_out_i), 32'(m_pending & m_enable));
      end
    end
  end

endmodule

//--- hw/ao_peripheral_subsystem.sv
/* Always-on peripheral subsystem: crossbar plus SoC control,
   timer, GPIO and fast interrupt controller */
`timescale 1ns/10ps

module ao_peripheral_subsystem
  import ao_periph_pkg::*;
#(
  parameter int unsigned NUM_GPIO      = 8,
  parameter int unsigned NUM_FAST_INTR = 15
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  input  obi_req_t                 slave_req_i,
  output obi_resp_t                slave_resp_o,

  // SoC control
  input  logic                     boot_select_i,
  output logic                     exit_valid_o,
  output logic [31:0]              exit_value_o,

  // GPIO
  input  logic [NUM_GPIO-1:0]      gpio_i,
  output logic [NUM_GPIO-1:0]      gpio_o,
  output logic [NUM_GPIO-1:0]      gpio_en_o,
  output logic [NUM_GPIO-1:0]      intr_gpio_o,

  output logic                     timer_intr_o,

  input  logic [NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [NUM_FAST_INTR-1:0] fast_intr_o
);

  reg_req_t [NUM_PERIPH-1:0] periph_req;
  reg_rsp_t [NUM_PERIPH-1:0] periph_rsp;

  ao_periph_xbar ao_periph_xbar_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .slave_req_i  (slave_req_i),
    .slave_resp_o (slave_resp_o),
    .periph_req_o (periph_req),
    .periph_rsp_i (periph_rsp)
  );

  soc_ctrl soc_ctrl_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reg_req_i     (periph_req[PERIPH_SOC_CTRL]),
    .reg_rsp_o     (periph_rsp[PERIPH_SOC_CTRL]),
    .boot_select_i (boot_select_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

  ao_timer ao_timer_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .reg_req_i    (periph_req[PERIPH_TIMER]),
    .reg_rsp_o    (periph_rsp[PERIPH_TIMER]),
    .timer_intr_o (timer_intr_o)
  );

  gpio_ao #(
    .NUM_GPIO (NUM_GPIO)
  ) gpio_ao_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_req_i   (periph_req[PERIPH_GPIO]),
    .reg_rsp_o   (periph_rsp[PERIPH_GPIO]),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_en_o   (gpio_en_o),
    .intr_gpio_o (intr_gpio_o)
  );

  fast_intr_ctrl #(
    .NUM_FAST_INTR (NUM_FAST_INTR)
  ) fast_intr_ctrl_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_req_i   (periph_req[PERIPH_FAST_INTR]),
    .reg_rsp_o   (periph_rsp[PERIPH_FAST_INTR]),
    .fast_intr_i (fast_intr_i),
    .fast_intr_o (fast_intr_o)
  );

endmodule

//--- hw/fast_intr_ctrl.sv
/* Fast interrupt controller: pending latch with enable mask */
`timescale 1ns/10ps

module fast_intr_ctrl
  import ao_periph_pkg::*;
#(
  parameter int unsigned NUM_FAST_INTR = 15
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  reg_req_t                 reg_req_i,
  output reg_rsp_t                 reg_rsp_o,
  input  logic [NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [NUM_FAST_INTR-1:0] fast_intr_o
);

  localparam logic [11:0] PENDING_OFS = 12'h000;
  localparam logic [11:0] ENABLE_OFS  = 12'h004;

  logic                     wr_en;
  logic [NUM_FAST_INTR-1:0] pending_q;
  logic [NUM_FAST_INTR-1:0] enable_q;
  logic [NUM_FAST_INTR-1:0] pending_clr;

  assign wr_en       = reg_req_i.valid && (reg_req_i.op == OP_WRITE);
  assign pending_clr = (wr_en && reg_req_i.offset == PENDING_OFS) ?
                       reg_req_i.wdata[NUM_FAST_INTR-1:0] : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // A live line keeps its bit set through a clear
      pending_q <= (pending_q & ~pending_clr) | fast_intr_i;
      if (wr_en && reg_req_i.offset == ENABLE_OFS) begin
        enable_q <= reg_req_i.wdata[NUM_FAST_INTR-1:0];
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.offset)
      PENDING_OFS: reg_rsp_o.rdata = 32'(pending_q);
      ENABLE_OFS:  reg_rsp_o.rdata = 32'(enable_q);
      default:     reg_rsp_o.error = reg_req_i.valid;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule

//--- hw/gpio_ao.sv
/* GPIO block: input synchronizer, output and output-enable registers,
   rising-edge interrupt status */
`timescale 1ns/10ps

module gpio_ao
  import ao_periph_pkg::*;
#(
  parameter int unsigned NUM_GPIO = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  reg_req_t            reg_req_i,
  output reg_rsp_t            reg_rsp_o,
  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_en_o,
  output logic [NUM_GPIO-1:0] intr_gpio_o
);

  localparam logic [11:0] DATA_IN_OFS     = 12'h000;
  localparam logic [11:0] DATA_OUT_OFS    = 12'h004;
  localparam logic [11:0] OUT_EN_OFS      = 12'h008;
  localparam logic [11:0] INTR_EN_OFS     = 12'h00C;
  localparam logic [11:0] INTR_STATUS_OFS = 12'h010;

  logic                wr_en;
  logic [NUM_GPIO-1:0] sync_q1;
  logic [NUM_GPIO-1:0] sync_q2;
  logic [NUM_GPIO-1:0] prev_q;
  logic [NUM_GPIO-1:0] rise;
  logic [NUM_GPIO-1:0] data_out_q;
  logic [NUM_GPIO-1:0] out_en_q;
  logic [NUM_GPIO-1:0] intr_en_q;
  logic [NUM_GPIO-1:0] intr_status_q;
  logic [NUM_GPIO-1:0] status_clr;
  logic [31:0]         data_out_wr;

  assign wr_en = reg_req_i.valid && (reg_req_i.op == OP_WRITE);
  assign rise  = sync_q2 & ~prev_q;

  assign status_clr = (wr_en && reg_req_i.offset == INTR_STATUS_OFS) ?
                      reg_req_i.wdata[NUM_GPIO-1:0] : '0;
  assign data_out_wr = apply_be(32'(data_out_q), reg_req_i.wdata, reg_req_i.be);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q1       <= '0;
      sync_q2       <= '0;
      prev_q        <= '0;
      intr_status_q <= '0;
    end else begin
      sync_q1       <= gpio_i;
      sync_q2       <= sync_q1;
      prev_q        <= sync_q2;
      intr_status_q <= (intr_status_q & ~status_clr) | (rise & intr_en_q);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_out_q <= '0;
      out_en_q   <= '0;
      intr_en_q  <= '0;
    end else if (wr_en) begin
      case (reg_req_i.offset)
        DATA_OUT_OFS: data_out_q <= data_out_wr[NUM_GPIO-1:0];
        OUT_EN_OFS:   out_en_q <= reg_req_i.wdata[NUM_GPIO-1:0];
        INTR_EN_OFS:  intr_en_q <= reg_req_i.wdata[NUM_GPIO-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.offset)
      DATA_IN_OFS:     reg_rsp_o.rdata = 32'(sync_q2);
      DATA_OUT_OFS:    reg_rsp_o.rdata = 32'(data_out_q);
      OUT_EN_OFS:      reg_rsp_o.rdata = 32'(out_en_q);
      INTR_EN_OFS:     reg_rsp_o.rdata = 32'(intr_en_q);
      INTR_STATUS_OFS: reg_rsp_o.rdata = 32'(intr_status_q);
      default:         reg_rsp_o.error = reg_req_i.valid;
    endcase
  end

  assign gpio_o      = data_out_q;
  assign gpio_en_o   = out_en_q;
  assign intr_gpio_o = intr_status_q;

endmodule

//--- hw/ao_timer.sv
/* Machine timer: free-running counter, compare register,
   control bits and a sticky write-one-to-clear status */
`timescale 1ns/10ps

module ao_timer
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output logic     timer_intr_o
);

  localparam logic [11:0] CTRL_OFS     = 12'h000;
  localparam logic [11:0] MTIME_OFS    = 12'h004;
  localparam logic [11:0] MTIMECMP_OFS = 12'h008;
  localparam logic [11:0] STATUS_OFS   = 12'h00C;

  typedef struct packed {
    logic intr_en;
    logic cnt_en;
  } timer_ctrl_t;

  logic        wr_en;
  timer_ctrl_t ctrl_q;
  logic [31:0] mtime_q;
  logic [31:0] mtimecmp_q;
  logic        status_q;
  logic        status_set;
  logic        status_clr;

  assign wr_en = reg_req_i.valid && (reg_req_i.op == OP_WRITE);

  assign status_set = ctrl_q.cnt_en && (mtime_q >= mtimecmp_q);
  assign status_clr = wr_en && (reg_req_i.offset == STATUS_OFS) && reg_req_i.wdata[0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_q     <= '0;
      mtimecmp_q <= '0;
    end else if (wr_en) begin
      case (reg_req_i.offset)
        CTRL_OFS:     ctrl_q <= timer_ctrl_t'(reg_req_i.wdata[1:0]);
        MTIMECMP_OFS: mtimecmp_q <= reg_req_i.wdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_q  <= '0;
      status_q <= 1'b0;
    end else begin
      if (ctrl_q.cnt_en) begin
        mtime_q <= mtime_q + 32'd1;
      end
      // Set wins over a clear in the same cycle
      if (status_set) begin
        status_q <= 1'b1;
      end else if (status_clr) begin
        status_q <= 1'b0;
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.offset)
      CTRL_OFS:     reg_rsp_o.rdata = {30'b0, ctrl_q};
      MTIME_OFS:    reg_rsp_o.rdata = mtime_q;
      MTIMECMP_OFS: reg_rsp_o.rdata = mtimecmp_q;
      STATUS_OFS:   reg_rsp_o.rdata = {31'b0, status_q};
      default:      reg_rsp_o.error = reg_req_i.valid;
    endcase
  end

  assign timer_intr_o = status_q && ctrl_q.intr_en;

  intr_needs_enable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !ctrl_q.intr_en |-> !timer_intr_o)
    else $error("timer_intr_o high with interrupt enable clear");

endmodule

//--- hw/soc_ctrl.sv
/* SoC control registers: sticky exit flag, exit value,
   boot-select readback and scratch word */
`timescale 1ns/10ps

module soc_ctrl
  import ao_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  reg_req_t    reg_req_i,
  output reg_rsp_t    reg_rsp_o,
  input  logic        boot_select_i,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o
);

  localparam logic [11:0] EXIT_VALID_OFS  = 12'h000;
  localparam logic [11:0] EXIT_VALUE_OFS  = 12'h004;
  localparam logic [11:0] BOOT_SELECT_OFS = 12'h008;
  localparam logic [11:0] SCRATCH_OFS     = 12'h00C;

  logic        wr_en;
  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic [31:0] scratch_q;

  assign wr_en = reg_req_i.valid && (reg_req_i.op == OP_WRITE);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q    <= '0;
    end else if (wr_en) begin
      case (reg_req_i.offset)
        EXIT_VALID_OFS: begin
          // Sticky until reset
          if (reg_req_i.wdata[0]) begin
            exit_valid_q <= 1'b1;
          end
        end
        EXIT_VALUE_OFS: exit_value_q <= reg_req_i.wdata;
        SCRATCH_OFS:    scratch_q <= apply_be(scratch_q, reg_req_i.wdata, reg_req_i.be);
        default: ;
      endcase
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.offset)
      EXIT_VALID_OFS:  reg_rsp_o.rdata = {31'b0, exit_valid_q};
      EXIT_VALUE_OFS:  reg_rsp_o.rdata = exit_value_q;
      BOOT_SELECT_OFS: reg_rsp_o.rdata = {31'b0, boot_select_i};
      SCRATCH_OFS:     reg_rsp_o.rdata = scratch_q;
      default:         reg_rsp_o.error = reg_req_i.valid;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

  exit_valid_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(exit_valid_o) |-> exit_valid_o)
    else $error("exit_valid_o fell without reset");

endmodule

//--- hw/ao_periph_xbar.sv
/* Bus to register-bus bridge with address decode, request demux
   and a registered response one cycle after each grant */
`timescale 1ns/10ps

module ao_periph_xbar
  import ao_periph_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  obi_req_t                  slave_req_i,
  output obi_resp_t                 slave_resp_o,
  output reg_req_t [NUM_PERIPH-1:0] periph_req_o,
  input  reg_rsp_t [NUM_PERIPH-1:0] periph_rsp_i
);

  logic        base_hit;
  logic        idx_hit;
  logic        dec_hit;
  periph_idx_e periph_sel;
  reg_rsp_t    sel_rsp;
  logic        err_d;
  logic [31:0] rdata_d;
  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  assign base_hit   = slave_req_i.addr[31:16] == AO_BASE_ADDR[31:16];
  assign idx_hit    = slave_req_i.addr[15:12] < 4'(NUM_PERIPH);
  assign dec_hit    = base_hit && idx_hit;
  assign periph_sel = periph_idx_e'(slave_req_i.addr[12 +: $bits(periph_idx_e)]);

  // Only the decoded slot sees valid
  always_comb begin
    for (int i = 0; i < NUM_PERIPH; i++) begin
      periph_req_o[i].valid  = slave_req_i.req && dec_hit && (periph_sel == periph_idx_e'(i));
      periph_req_o[i].op     = slave_req_i.we ? OP_WRITE : OP_READ;
      periph_req_o[i].offset = slave_req_i.addr[11:0];
      periph_req_o[i].wdata  = slave_req_i.wdata;
      periph_req_o[i].be     = slave_req_i.be;
    end
  end

  assign sel_rsp = periph_rsp_i[periph_sel];

  always_comb begin
    err_d   = 1'b0;
    rdata_d = '0;
    if (slave_req_i.req) begin
      if (!dec_hit) begin
        err_d = 1'b1;
      end else begin
        err_d = sel_rsp.error;
        // Write responses and errors carry no data
        if (!slave_req_i.we && !sel_rsp.error) begin
          rdata_d = sel_rsp.rdata;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= slave_req_i.req;
      err_q    <= err_d;
      rdata_q  <= rdata_d;
    end
  end

  // Always granted, no back-pressure
  assign slave_resp_o.gnt    = slave_req_i.req;
  assign slave_resp_o.rvalid = rvalid_q;
  assign slave_resp_o.err    = err_q;
  assign slave_resp_o.rdata  = rdata_q;

  rvalid_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slave_resp_o.rvalid == $past(slave_req_i.req))
    else $error("rvalid not one cycle after req");

endmodule

//--- hw/ao_periph_pkg.sv
/* Bus request and response structs, register-bus opcodes,
   peripheral select enum, address map and a byte-enable merge helper */
package ao_periph_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } reg_op_e;

  // Byte enables ride along for the registers that honour them
  typedef struct packed {
    logic        valid;
    reg_op_e     op;
    logic [11:0] offset;
    logic [31:0] wdata;
    logic [3:0]  be;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
  } reg_rsp_t;

  localparam int unsigned NUM_PERIPH = 4;

  // Selected by address bits 15:12
  typedef enum logic [$clog2(NUM_PERIPH)-1:0] {
    PERIPH_SOC_CTRL  = 0,
    PERIPH_TIMER     = 1,
    PERIPH_GPIO      = 2,
    PERIPH_FAST_INTR = 3
  } periph_idx_e;

  localparam logic [31:0] AO_BASE_ADDR = 32'h2000_0000;

  function automatic logic [31:0] apply_be(input logic [31:0] old_val,
                                           input logic [31:0] new_val,
                                           input logic [3:0]  be);
    logic [31:0] merged;
    for (int b = 0; b < 4; b++) begin
      merged[8*b +: 8] = be[b] ? new_val[8*b +: 8] : old_val[8*b +: 8];
    end
    return merged;
  endfunction

endpackage
